//--- project.f
+incdir+include
design/cache_pkg.sv
design/cache_req_gen.sv
design/cache_core.sv
design/cache_mem_if.sv
design/cache_subsys_top.sv
verif/cache_checker.sv
verif/tb_cache_subsys.sv

//--- Bender.yml
package:
  name: cache_subsys

export_include_dirs:
  - include

sources:
  - design/cache_pkg.sv
  - design/cache_req_gen.sv
  - design/cache_core.sv
  - design/cache_mem_if.sv
  - design/cache_subsys_top.sv
  - target: simulation
    files:
      - verif/cache_checker.sv
      - verif/tb_cache_subsys.sv

//--- verif/cache_testdata.txt
// columns: test id, base address, word count, pattern (all hex)
// ids from 10 up get a long memory ready delay, a zero id ends the list
01 0000000000001000 0008 a5a55a5a0f0ff0f0
02 0000000000002040 0014 0123456789abcdef
03 0000000000000000 0020 8000000000000001
04 0000000080000000 003c deadbeefcafef00d
05 00000000000100c0 0046 00000000000000ff
11 0000000000004000 0040 5555aaaa3333cccc
12 0000000000003080 000b fedcba9876543210
00 0000000000000000 0000 0000000000000000

//--- verif/tb_cache_subsys.sv
// ~~~~~~~~~~~~~~~~~~~~
// testbench: clock, reset, memory model and file-driven test runs
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`include "cache_defs.svh"

module tb_cache_subsys;

  import cache_pkg::*;

  localparam int MAX_TESTS = 16;

  logic                clk;
  logic                rst;
  logic                start;
  logic [`ADDR_W-1:0]  base_addr;
  logic [15:0]         num_words;
  logic [`WORD_W-1:0]  pattern;
  logic [7:0]          test_id;
  logic                busy;
  logic                done;
  logic [15:0]         mismatch_count;
  logic                mem_valid;
  req_op_e             mem_op;
  logic [`ADDR_W-1:0]  mem_addr;
  logic [`LINE_W-1:0]  mem_wdata;
  size_e               mem_size;
  logic [7:0]          mem_blks;
  logic                mem_ready;
  logic [`LINE_W-1:0]  mem_rdata;

  logic [`LINE_W-1:0]  mem_lines [logic [`ADDR_W-1:0]];  // unwritten lines read as zero
  logic [63:0]         test_rows [4*MAX_TESTS];
  logic [31:0]         lfsr_q;
  logic                mem_pending;
  int                  mem_wait;
  int                  num_tests;
  int                  cycles;
  int                  cycle_limit;
  int                  errors;
  int                  checks;

  initial clk = 1'b0;
  always #4 clk = ~clk;

  cache_subsys_top dut0 (
    .clk              (clk),
    .rst              (rst),
    .i_start          (start),
    .i_base_addr      (base_addr),
    .i_num_words      (num_words),
    .i_pattern        (pattern),
    .o_busy           (busy),
    .o_done           (done),
    .o_mismatch_count (mismatch_count),
    .o_mem_valid      (mem_valid),
    .o_mem_op         (mem_op),
    .o_mem_addr       (mem_addr),
    .o_mem_wdata      (mem_wdata),
    .o_mem_size       (mem_size),
    .o_mem_blks       (mem_blks),
    .i_mem_ready      (mem_ready),
    .i_mem_rdata      (mem_rdata)
  );

  cache_checker u_checker (
    .clk              (clk),
    .rst              (rst),
    .i_test_id        (test_id),
    .i_start          (start),
    .i_base_addr      (base_addr),
    .i_num_words      (num_words),
    .i_pattern        (pattern),
    .i_busy           (busy),
    .i_done           (done),
    .i_mismatch_count (mismatch_count),
    .i_mem_valid      (mem_valid),
    .i_mem_op         (mem_op),
    .i_mem_addr       (mem_addr),
    .i_mem_wdata      (mem_wdata),
    .i_mem_size       (mem_size),
    .i_mem_blks       (mem_blks),
    .i_mem_ready      (mem_ready),
    .o_errors         (errors),
    .o_checks         (checks)
  );

  // galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_delay(input int nbits, output int d);
    int i;
    d = 0;
    for (i = 0; i < nbits; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      d      = (d << 1) | int'(lfsr_q[0]);
    end
  endtask

  task automatic serve_request();
    if (mem_op == REQ_WRITE)
      mem_lines[mem_addr] = mem_wdata;
    else
      mem_rdata = mem_lines.exists(mem_addr) ? mem_lines[mem_addr] : '0;
    mem_ready = 1'b1;
  endtask

  // memory model, ready after 0..3 cycles, 0..15 for ids from 10 up
  always @(negedge clk) begin
    if (rst) begin
      mem_ready   = 1'b0;
      mem_pending = 1'b0;
    end else if (mem_ready) begin
      mem_ready   = 1'b0;
      mem_pending = 1'b0;
    end else if (mem_valid) begin
      if (!mem_pending) begin
        mem_pending = 1'b1;
        draw_delay((test_id >= 8'h10) ? 4 : 2, mem_wait);
      end
      if (mem_wait == 0)
        serve_request();
      else
        mem_wait--;
    end
  end

  task automatic run_test(input int t);
    @(negedge clk);
    rst     = 1'b1;
    test_id = test_rows[4*t][7:0];
    mem_lines.delete();   // fresh memory and empty cache per test
    repeat (5) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    start     = 1'b1;
    base_addr = test_rows[4*t+1];
    num_words = test_rows[4*t+2][15:0];
    pattern   = test_rows[4*t+3];
    @(negedge clk);
    start = 1'b0;
    do @(negedge clk); while (!done);
    repeat (4) @(negedge clk);  // room for a stray second done
  endtask

  initial begin
    int limit;
    int t;
    rst       = 1'b1;
    start     = 1'b0;
    base_addr = '0;
    num_words = '0;
    pattern   = '0;
    test_id   = '0;
    mem_ready = 1'b0;
    mem_rdata = '0;
    lfsr_q    = 32'h0b69_a35c;
    num_tests = 0;
    cycles    = 0;
    $readmemh("verif/cache_testdata.txt", test_rows);
    limit = 1000;
    while (num_tests < MAX_TESTS && test_rows[4*num_tests] != 64'd0) begin
      limit += 400 * int'(test_rows[4*num_tests+2]);
      num_tests++;
    end
    cycle_limit = limit;
    for (t = 0; t < num_tests; t++)
      run_test(t);
    $display("summary: %0d tests, %0d checks, %0d errors", num_tests, checks, errors);
    if (errors == 0 && num_tests > 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // run limit from the total word count
  initial begin
    wait (cycle_limit > 0);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    $display("Something failed");
    $finish;
  end

endmodule

//--- verif/cache_checker.sv
// ~~~~~~~~~~~~~~~~~~~~
// checker: memory port rules, writeback data and per-test transfer counts
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`include "cache_defs.svh"

module cache_checker (
  input  logic                clk,
  input  logic                rst,
  input  logic [7:0]          i_test_id,
  input  logic                i_start,
  input  logic [`ADDR_W-1:0]  i_base_addr,
  input  logic [15:0]         i_num_words,
  input  logic [`WORD_W-1:0]  i_pattern,
  input  logic                i_busy,
  input  logic                i_done,
  input  logic [15:0]         i_mismatch_count,
  input  logic                i_mem_valid,
  input  cache_pkg::req_op_e  i_mem_op,
  input  logic [`ADDR_W-1:0]  i_mem_addr,
  input  logic [`LINE_W-1:0]  i_mem_wdata,
  input  cache_pkg::size_e    i_mem_size,
  input  logic [7:0]          i_mem_blks,
  input  logic                i_mem_ready,
  output int                  o_errors,
  output int                  o_checks
);

  import cache_pkg::*;

  string                          name;
  logic [`ADDR_W-1:0]             base_q;
  logic [15:0]                    num_q;
  logic [`WORD_W-1:0]             pat_q;
  int                             refills;
  int                             wbacks;
  int                             dones;
  int                             lines;
  logic                           running;      // between start and done
  logic                           prev_valid;
  logic                           prev_ready;
  logic [`ADDR_W+`LINE_W+10:0]    prev_fields;  // op, addr, wdata, size, blks

  initial begin
    o_errors = 0;
    o_checks = 0;
    name     = "none";
    running  = 1'b0;
  end

  task automatic check_value(input string what, input logic [`WORD_W-1:0] exp,
                             input logic [`WORD_W-1:0] act);
    o_checks++;
    if (exp !== act) begin
      o_errors++;
      $display("FAIL %s %s: expected %h actual %h", name, what, exp, act);
    end
  endtask

  task automatic report_error(input string what);
    o_errors++;
    $display("ERROR %s: %s", name, what);
  endtask

  // base pattern turned left one bit at a time, k mod 64 turns
  function automatic logic [`WORD_W-1:0] pattern_word(input logic [`ADDR_W-1:0] k);
    logic [`WORD_W-1:0] w;
    int                 i;
    w = pat_q;
    for (i = 0; i < int'(k % 64); i++)
      w = {w[`WORD_W-2:0], w[`WORD_W-1]};
    return w;
  endfunction

  // in-range words carry the pattern, the rest of the line stays zero
  task automatic check_line(input logic [`ADDR_W-1:0] addr, input logic [`LINE_W-1:0] line);
    logic [`ADDR_W-1:0] a;
    logic [`WORD_W-1:0] exp;
    int                 w;
    for (w = 0; w < 8; w++) begin
      a = addr + 64'(w * 8);
      if (a >= base_q && a < base_q + 64'(num_q) * 8)
        exp = pattern_word((a - base_q) >> 3);
      else
        exp = '0;
      check_value($sformatf("writeback word at %h", a), exp, line[w*`WORD_W +: `WORD_W]);
    end
  endtask

  always @(posedge clk) begin
    if (i_start) begin
      name    = $sformatf("test_%02h", i_test_id);
      base_q  = i_base_addr;
      num_q   = i_num_words;
      pat_q   = i_pattern;
      refills = 0;
      wbacks  = 0;
      dones   = 0;
    end
    if (rst) begin
      prev_valid = 1'b0;
      prev_ready = 1'b0;
      running    = 1'b0;
    end else begin
      check_value("busy", running, i_busy);  // high from after start through done
      if (prev_valid && !prev_ready) begin
        o_checks++;
        if (!i_mem_valid)
          report_error("memory request dropped before ready");
        else if ({i_mem_op, i_mem_addr, i_mem_wdata, i_mem_size, i_mem_blks} !== prev_fields)
          report_error("memory request changed while waiting for ready");
      end
      if (i_mem_valid) begin
        check_value("address offset", '0, i_mem_addr[5:0]);
        check_value("size", SIZE_D, i_mem_size);
        check_value("blks", 64'd7, i_mem_blks);
      end
      if (i_mem_valid && i_mem_ready) begin
        if (i_mem_op == REQ_WRITE) begin
          wbacks++;
          check_line(i_mem_addr, i_mem_wdata);
        end else begin
          refills++;
        end
      end
      if (i_done) begin
        if (dones != 0)
          report_error("more than one done pulse in a test");
        dones++;
        lines = (int'(num_q) + 7) / 8;
        check_value("mismatch count", '0, i_mismatch_count);
        // sequential conflicts once the run wraps the four sets
        check_value("refills", (lines <= 4) ? lines : 2 * lines, refills);
        check_value("writebacks", (lines <= 4) ? 0 : lines, wbacks);
      end
      if (i_start)
        running = 1'b1;
      if (i_done)
        running = 1'b0;
      prev_valid  = i_mem_valid;
      prev_ready  = i_mem_ready;
      prev_fields = {i_mem_op, i_mem_addr, i_mem_wdata, i_mem_size, i_mem_blks};
    end
  end

endmodule

//--- design/cache_subsys_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// cache subsystem: generator, cache and line mover
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`include "cache_defs.svh"

module cache_subsys_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_start,
  input  logic [`ADDR_W-1:0]    i_base_addr,
  input  logic [15:0]           i_num_words,
  input  logic [`WORD_W-1:0]    i_pattern,
  output logic                  o_busy,
  output logic                  o_done,
  output logic [15:0]           o_mismatch_count,
  output logic                  o_mem_valid,
  output cache_pkg::req_op_e    o_mem_op,
  output logic [`ADDR_W-1:0]    o_mem_addr,
  output logic [`LINE_W-1:0]    o_mem_wdata,
  output cache_pkg::size_e      o_mem_size,
  output logic [7:0]            o_mem_blks,
  input  logic                  i_mem_ready,
  input  logic [`LINE_W-1:0]    i_mem_rdata
);

  import cache_pkg::*;

  // generator to cache
  logic                req;
  req_op_e             req_op;
  logic [`ADDR_W-1:0]  req_addr;
  logic [`WORD_W-1:0]  req_wdata;
  size_e               req_size;
  logic                ack;
  logic [`WORD_W-1:0]  rdata;

  // cache to line mover
  logic                xfer_start;
  req_op_e             xfer_op;
  logic [`ADDR_W-1:0]  xfer_addr;
  logic [`LINE_W-1:0]  xfer_line;
  logic                xfer_done;
  logic [`LINE_W-1:0]  xfer_rline;

  cache_req_gen u_gen (
    .clk              (clk),
    .rst              (rst),
    .i_start          (i_start),
    .i_base_addr      (i_base_addr),
    .i_num_words      (i_num_words),
    .i_pattern        (i_pattern),
    .i_ack            (ack),
    .i_rdata          (rdata),
    .o_req            (req),
    .o_op             (req_op),
    .o_addr           (req_addr),
    .o_wdata          (req_wdata),
    .o_size           (req_size),
    .o_busy           (o_busy),
    .o_done           (o_done),
    .o_mismatch_count (o_mismatch_count)
  );

  cache_core u_core (
    .clk          (clk),
    .rst          (rst),
    .i_req        (req),
    .i_op         (req_op),
    .i_addr       (req_addr),
    .i_wdata      (req_wdata),
    .i_size       (req_size),
    .o_ack        (ack),
    .o_rdata      (rdata),
    .o_xfer_start (xfer_start),
    .o_xfer_op    (xfer_op),
    .o_xfer_addr  (xfer_addr),
    .o_xfer_line  (xfer_line),
    .i_xfer_done  (xfer_done),
    .i_xfer_rline (xfer_rline)
  );

  cache_mem_if u_mem_if (
    .clk          (clk),
    .rst          (rst),
    .i_xfer_start (xfer_start),
    .i_xfer_op    (xfer_op),
    .i_xfer_addr  (xfer_addr),
    .i_xfer_line  (xfer_line),
    .o_xfer_done  (xfer_done),
    .o_xfer_rline (xfer_rline),
    .o_mem_valid  (o_mem_valid),
    .o_mem_op     (o_mem_op),
    .o_mem_addr   (o_mem_addr),
    .o_mem_wdata  (o_mem_wdata),
    .o_mem_size   (o_mem_size),
    .o_mem_blks   (o_mem_blks),
    .i_mem_ready  (i_mem_ready),
    .i_mem_rdata  (i_mem_rdata)
  );

endmodule

//--- design/cache_mem_if.sv
// ~~~~~~~~~~~~~~~~~~~~
// line mover: one writeback or refill on the external memory port
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`include "cache_defs.svh"

module cache_mem_if (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_xfer_start,
  input  cache_pkg::req_op_e    i_xfer_op,
  input  logic [`ADDR_W-1:0]    i_xfer_addr,
  input  logic [`LINE_W-1:0]    i_xfer_line,
  output logic                  o_xfer_done,
  output logic [`LINE_W-1:0]    o_xfer_rline,
  output logic                  o_mem_valid,
  output cache_pkg::req_op_e    o_mem_op,
  output logic [`ADDR_W-1:0]    o_mem_addr,
  output logic [`LINE_W-1:0]    o_mem_wdata,
  output cache_pkg::size_e      o_mem_size,
  output logic [7:0]            o_mem_blks,
  input  logic                  i_mem_ready,
  input  logic [`LINE_W-1:0]    i_mem_rdata
);

  import cache_pkg::*;

  logic busy;
  logic mem_hs;

  assign busy   = o_mem_valid || o_xfer_done;
  assign mem_hs = o_mem_valid && i_mem_ready;

  // whole line as eight doublewords
  assign o_mem_size = SIZE_D;
  assign o_mem_blks = 8'd7;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_mem_valid <= 1'b0;
      o_xfer_done <= 1'b0;
    end else begin
      o_xfer_done <= 1'b0;
      if (i_xfer_start && !busy) begin
        o_mem_valid <= 1'b1;
      end else if (mem_hs) begin
        o_mem_valid <= 1'b0;
        o_xfer_done <= 1'b1;   // one cycle after ready
      end
    end
  end

  // request fields held steady until ready
  always_ff @(posedge clk) begin
    if (i_xfer_start && !busy) begin
      o_mem_op    <= i_xfer_op;
      o_mem_addr  <= i_xfer_addr;
      o_mem_wdata <= i_xfer_line;
    end
    if (mem_hs && o_mem_op == REQ_READ)
      o_xfer_rline <= i_mem_rdata;  // refill data
  end

  a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
    i_xfer_start |-> !busy);

endmodule

//--- design/cache_core.sv
// ~~~~~~~~~~~~~~~~~~~~
// direct-mapped write-back data cache, four 64-byte lines
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`include "cache_defs.svh"

module cache_core (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_req,
  input  cache_pkg::req_op_e    i_op,
  input  logic [`ADDR_W-1:0]    i_addr,
  input  logic [`WORD_W-1:0]    i_wdata,
  input  cache_pkg::size_e      i_size,
  output logic                  o_ack,
  output logic [`WORD_W-1:0]    o_rdata,
  output logic                  o_xfer_start,
  output cache_pkg::req_op_e    o_xfer_op,
  output logic [`ADDR_W-1:0]    o_xfer_addr,
  output logic [`LINE_W-1:0]    o_xfer_line,
  input  logic                  i_xfer_done,
  input  logic [`LINE_W-1:0]    i_xfer_rline
);

  import cache_pkg::*;

  localparam int OFF_W  = $clog2(`LINE_BYTES);
  localparam int IDX_W  = $clog2(`CACHE_SETS);
  localparam int TAG_W  = `ADDR_W - IDX_W - OFF_W;
  localparam int WSEL_W = OFF_W - 3;  // doubleword select within a line

  core_state_e             state_q;
  logic [TAG_W-1:0]        tag_q   [`CACHE_SETS];
  logic [`LINE_W-1:0]      data_q  [`CACHE_SETS];
  logic [`CACHE_SETS-1:0]  valid_q;
  logic [`CACHE_SETS-1:0]  dirty_q;

  logic [IDX_W-1:0]        set_idx;
  logic [TAG_W-1:0]        req_tag;
  logic [WSEL_W-1:0]       word_sel;
  logic [`ADDR_W-1:0]      line_addr;
  logic                    hit;
  logic                    accept;
  logic                    is_write;

  // drop one doubleword into a line
  function automatic logic [`LINE_W-1:0] merge_word(input logic [`LINE_W-1:0] line,
                                                    input logic [WSEL_W-1:0] sel,
                                                    input logic [`WORD_W-1:0] word);
    logic [`LINE_W-1:0] res;
    res = line;
    res[sel*`WORD_W +: `WORD_W] = word;
    return res;
  endfunction

  assign set_idx   = i_addr[OFF_W +: IDX_W];   // bits 7:6
  assign req_tag   = i_addr[`ADDR_W-1 -: TAG_W];
  assign word_sel  = i_addr[3 +: WSEL_W];
  assign line_addr = {i_addr[`ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
  assign hit       = valid_q[set_idx] && (tag_q[set_idx] == req_tag);
  assign accept    = i_req && !o_ack;  // req is still high in the ack cycle
  assign is_write  = (i_op == REQ_WRITE);

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= LOOKUP;
      valid_q      <= '0;
      dirty_q      <= '0;
      o_ack        <= 1'b0;
      o_xfer_start <= 1'b0;
    end else begin
      o_ack        <= 1'b0;
      o_xfer_start <= 1'b0;
      case (state_q)
        LOOKUP: begin
          if (accept) begin
            if (hit) begin
              o_ack <= 1'b1;
              if (is_write)
                dirty_q[set_idx] <= 1'b1;
            end else begin
              o_xfer_start <= 1'b1;
              state_q      <= (valid_q[set_idx] && dirty_q[set_idx]) ? EVICT : REFILL;
            end
          end
        end
        EVICT: begin
          if (i_xfer_done) begin
            o_xfer_start <= 1'b1;   // now fetch the new line
            state_q      <= REFILL;
          end
        end
        REFILL: begin
          if (i_xfer_done) begin
            valid_q[set_idx] <= 1'b1;
            dirty_q[set_idx] <= is_write;
            o_ack            <= 1'b1;
            state_q          <= RESPOND;
          end
        end
        default: state_q <= LOOKUP;
      endcase
    end
  end

  // arrays, read data and transfer payload
  always_ff @(posedge clk) begin
    case (state_q)
      LOOKUP: begin
        if (accept && hit) begin
          o_rdata <= data_q[set_idx][word_sel*`WORD_W +: `WORD_W];
          if (is_write)
            data_q[set_idx] <= merge_word(data_q[set_idx], word_sel, i_wdata);
        end else if (accept && valid_q[set_idx] && dirty_q[set_idx]) begin
          o_xfer_op   <= REQ_WRITE;
          o_xfer_addr <= {tag_q[set_idx], set_idx, {OFF_W{1'b0}}};
          o_xfer_line <= data_q[set_idx];
        end else if (accept) begin
          o_xfer_op   <= REQ_READ;
          o_xfer_addr <= line_addr;
        end
      end
      EVICT: begin
        if (i_xfer_done) begin
          o_xfer_op   <= REQ_READ;
          o_xfer_addr <= line_addr;
        end
      end
      REFILL: begin
        if (i_xfer_done) begin
          tag_q[set_idx] <= req_tag;
          o_rdata        <= i_xfer_rline[word_sel*`WORD_W +: `WORD_W];
          data_q[set_idx] <= is_write ? merge_word(i_xfer_rline, word_sel, i_wdata)
                                      : i_xfer_rline;
        end
      end
      default: ;
    endcase
  end

  a_size_d: assert property (@(posedge clk) disable iff (rst)
    i_req |-> i_size == SIZE_D);

  a_addr_aligned: assert property (@(posedge clk) disable iff (rst)
    i_req |-> i_addr[2:0] == 3'b000);

endmodule

//--- design/cache_req_gen.sv
// ~~~~~~~~~~~~~~~~~~~~
// traffic generator: writes a pattern run, reads it back, counts mismatches
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`include "cache_defs.svh"

module cache_req_gen (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_start,
  input  logic [`ADDR_W-1:0]    i_base_addr,
  input  logic [15:0]           i_num_words,
  input  logic [`WORD_W-1:0]    i_pattern,
  input  logic                  i_ack,
  input  logic [`WORD_W-1:0]    i_rdata,
  output logic                  o_req,
  output cache_pkg::req_op_e    o_op,
  output logic [`ADDR_W-1:0]    o_addr,
  output logic [`WORD_W-1:0]    o_wdata,
  output cache_pkg::size_e      o_size,
  output logic                  o_busy,
  output logic                  o_done,
  output logic [15:0]           o_mismatch_count
);

  import cache_pkg::*;

  localparam int GAP_W_BITS = $clog2(`GEN_GAP_CYCLES + 1);

  gen_state_e              state_q;
  logic [GAP_W_BITS-1:0]   gap_cnt_q;
  logic [15:0]             idx_q;
  logic [15:0]             num_q;
  logic [`ADDR_W-1:0]      base_q;
  logic [`WORD_W-1:0]      pattern_q;
  logic [`WORD_W-1:0]      expect_word;
  logic                    gap_over;
  logic                    last_word;

  // pattern rotated left by k (mod 64)
  function automatic logic [`WORD_W-1:0] rotl(input logic [`WORD_W-1:0] val,
                                              input logic [5:0] amt);
    logic [6:0] back;
    back = 7'd64 - {1'b0, amt};
    return (val << amt) | (val >> back);
  endfunction

  assign expect_word = rotl(pattern_q, idx_q[5:0]);
  assign gap_over    = (gap_cnt_q == GAP_W_BITS'(`GEN_GAP_CYCLES - 1));
  assign last_word   = (idx_q == num_q - 16'd1);

  assign o_addr  = base_q + {idx_q, 3'b000};  // 8 bytes per word
  assign o_wdata = expect_word;
  assign o_op    = (state_q == GAP_W || state_q == WRITE) ? REQ_WRITE : REQ_READ;
  assign o_size  = SIZE_D;
  assign o_busy  = (state_q != IDLE);
  assign o_done  = (state_q == DONE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q          <= IDLE;
      o_req            <= 1'b0;
      gap_cnt_q        <= '0;
      idx_q            <= '0;
      o_mismatch_count <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (i_start) begin
            gap_cnt_q        <= '0;
            idx_q            <= '0;
            o_mismatch_count <= '0;
            state_q          <= (i_num_words == 16'd0) ? DONE : GAP_W;
          end
        end
        GAP_W, GAP_R: begin
          gap_cnt_q <= gap_cnt_q + 1'b1;
          if (gap_over) begin
            gap_cnt_q <= '0;
            o_req     <= 1'b1;
            state_q   <= (state_q == GAP_W) ? WRITE : READ;
          end
        end
        WRITE: begin
          if (i_ack) begin
            o_req <= 1'b0;
            if (last_word) begin
              idx_q   <= '0;    // read back from the start
              state_q <= GAP_R;
            end else begin
              idx_q   <= idx_q + 16'd1;
              state_q <= GAP_W;
            end
          end
        end
        READ: begin
          if (i_ack) begin
            o_req <= 1'b0;
            if (i_rdata != expect_word)
              o_mismatch_count <= o_mismatch_count + 16'd1;
            idx_q   <= idx_q + 16'd1;
            state_q <= last_word ? DONE : GAP_R;
          end
        end
        default: state_q <= IDLE;  // DONE lasts one cycle
      endcase
    end
  end

  // run parameters, held for the whole run
  always_ff @(posedge clk) begin
    if (state_q == IDLE && i_start) begin
      base_q    <= i_base_addr;
      num_q     <= i_num_words;
      pattern_q <= i_pattern;
    end
  end

  // a new request never directly follows an ack
  a_no_req_after_ack: assert property (@(posedge clk) disable iff (rst)
    $rose(o_req) |-> !$past(i_ack));

endmodule

//--- design/cache_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// cache subsystem enums for ops, sizes and FSM states
// ~~~~~~~~~~~~~~~~~~~~

package cache_pkg;

  typedef enum logic {
    REQ_READ  = 1'b0,
    REQ_WRITE = 1'b1
  } req_op_e;

  // access size, only SIZE_D is issued here
  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2,
    SIZE_D = 2'd3
  } size_e;

  typedef enum logic [2:0] {
    IDLE,
    GAP_W,   // wait before a write
    WRITE,
    GAP_R,   // wait before a read
    READ,
    DONE
  } gen_state_e;

  typedef enum logic [1:0] {
    LOOKUP,
    EVICT,   // dirty line going out
    REFILL,
    RESPOND
  } core_state_e;

endpackage

//--- include/cache_defs.svh
// ~~~~~~~~~~~~~~~~~~~~
// cache subsystem widths, geometry and generator delays
// ~~~~~~~~~~~~~~~~~~~~

`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// bus widths
`define ADDR_W          64
`define WORD_W          64
`define LINE_W          512

// cache geometry
`define LINE_BYTES      64
`define CACHE_SETS      4     // direct-mapped, one line per set

// idle cycles the generator waits before each request
`define GEN_GAP_CYCLES  10

`endif
